/* pipe_pkg.sv */
`default_nettype none

package pipe_pkg;

    // sequence tag carried by every instruction
    localparam int TAG_W = 8;

    // register index, r0 never takes part in a hazard
    localparam int REG_W = 3;

    // where a tracked instruction currently sits
    typedef enum logic [2:0] {
        EMPTY      = 3'd0,
        FETCH      = 3'd1,
        DECODE     = 3'd2,
        EXECUTE    = 3'd3,
        MEMORY     = 3'd4,
        WRITE_BACK = 3'd5
    } stage_t;

    typedef enum logic [2:0] {
        OP_NOP    = 3'd0,
        OP_ALU    = 3'd1,
        OP_LOAD   = 3'd2,
        OP_STORE  = 3'd3,
        OP_BRANCH = 3'd4
    } op_t;

endpackage

`default_nettype wire

/* trace_pkg.sv */
`default_nettype none

package trace_pkg;

    // free-running cycle counter and fetch stamp
    localparam int CYCLE_W = 32;

    // fetch and decode residency, saturating
    localparam int CNT_W = 4;

    // config register map
    localparam logic [1:0] CFG_CTRL    = 2'd0;
    localparam logic [1:0] CFG_RETIRED = 2'd1;
    localparam logic [1:0] CFG_FLUSHED = 2'd2;
    localparam logic [1:0] CFG_STALLS  = 2'd3;

endpackage

`default_nettype wire

/* hazard_unit.sv */
`timescale 1ns/1ns
`default_nettype none

module hazard_unit (
    input  logic                       id_valid,
    input  logic [pipe_pkg::REG_W-1:0] id_rs1,
    input  logic [pipe_pkg::REG_W-1:0] id_rs2,
    input  logic                       ex_valid,
    input  pipe_pkg::op_t              ex_op,
    input  logic [pipe_pkg::REG_W-1:0] ex_rd,
    input  logic                       ex_taken,
    input  logic                       fetch_hold,
    output logic                       pc_stall,
    output logic                       if_id_stall,
    output logic                       if_flush
);
    import pipe_pkg::*;

    logic load_in_ex;
    logic rs1_hit;
    logic rs2_hit;

    // a load writing r0 produces nothing to wait for
    assign load_in_ex = ex_valid && (ex_op == OP_LOAD) && (ex_rd != '0);

    assign rs1_hit = (id_rs1 == ex_rd);
    assign rs2_hit = (id_rs2 == ex_rd);

    // load-use, decode waits one cycle for the load
    assign if_id_stall = id_valid && load_in_ex && (rs1_hit || rs2_hit);

    assign pc_stall = if_id_stall || fetch_hold;

    // taken branch resolved in execute
    assign if_flush = ex_valid && (ex_op == OP_BRANCH) && ex_taken;

endmodule

`default_nettype wire

/* pipe_core.sv */
`timescale 1ns/1ns
`default_nettype none

module pipe_core (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       instr_valid,
    input  pipe_pkg::op_t              instr_op,
    input  logic [pipe_pkg::REG_W-1:0] instr_rd,
    input  logic [pipe_pkg::REG_W-1:0] instr_rs1,
    input  logic [pipe_pkg::REG_W-1:0] instr_rs2,
    input  logic                       instr_taken,
    input  logic [pipe_pkg::TAG_W-1:0] instr_tag,
    input  logic                       pc_stall,
    input  logic                       if_id_stall,
    input  logic                       if_flush,
    output logic                       id_valid,
    output logic [pipe_pkg::REG_W-1:0] id_rs1,
    output logic [pipe_pkg::REG_W-1:0] id_rs2,
    output logic                       ex_valid,
    output pipe_pkg::op_t              ex_op,
    output logic [pipe_pkg::REG_W-1:0] ex_rd,
    output logic                       ex_taken,
    output logic                       wb_valid,
    output pipe_pkg::op_t              wb_op,
    output logic [pipe_pkg::TAG_W-1:0] wb_tag,
    output logic                       wb_flushed
);
    import pipe_pkg::*;

    logic             accept;
    logic             if_adv;
    logic             id_adv;

    logic             if_valid;
    op_t              if_op;
    logic [REG_W-1:0] if_rd;
    logic [REG_W-1:0] if_rs1;
    logic [REG_W-1:0] if_rs2;
    logic             if_taken;
    logic [TAG_W-1:0] if_tag;

    op_t              id_op;
    logic [REG_W-1:0] id_rd;
    logic             id_taken;
    logic [TAG_W-1:0] id_tag;
    logic             id_flushed;

    logic [TAG_W-1:0] ex_tag;
    logic             ex_flushed;

    logic             mem_valid;
    op_t              mem_op;
    logic [TAG_W-1:0] mem_tag;
    logic             mem_flushed;

    assign accept = instr_valid && !pc_stall;

    // flush wins over any stall on the front end
    assign if_adv = !pc_stall || if_flush;
    assign id_adv = !if_id_stall || if_flush;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            if_valid    <= 1'b0;
            id_valid    <= 1'b0;
            id_flushed  <= 1'b0;
            ex_valid    <= 1'b0;
            ex_flushed  <= 1'b0;
            mem_valid   <= 1'b0;
            mem_flushed <= 1'b0;
            wb_valid    <= 1'b0;
            wb_flushed  <= 1'b0;
        end else begin
            if (accept) begin
                if_valid <= 1'b1;
            end else if (if_adv) begin
                if_valid <= 1'b0;
            end
            if (id_adv) begin
                id_valid   <= if_adv && if_valid;
                id_flushed <= if_flush;
                ex_valid   <= id_valid;
                ex_flushed <= id_flushed || if_flush;
            end else begin
                // load-use bubble
                ex_valid   <= 1'b0;
                ex_flushed <= 1'b0;
            end
            mem_valid   <= ex_valid;
            mem_flushed <= ex_flushed;
            wb_valid    <= mem_valid;
            wb_flushed  <= mem_flushed;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            if_op    <= instr_op;
            if_rd    <= instr_rd;
            if_rs1   <= instr_rs1;
            if_rs2   <= instr_rs2;
            if_taken <= instr_taken;
            if_tag   <= instr_tag;
        end
        if (if_adv) begin
            id_op    <= if_op;
            id_rd    <= if_rd;
            id_rs1   <= if_rs1;
            id_rs2   <= if_rs2;
            id_taken <= if_taken && !if_flush;
            id_tag   <= if_tag;
        end
        // flushed entries lose their taken bit so they cannot flush again
        if (id_adv) begin
            ex_op    <= id_op;
            ex_rd    <= id_rd;
            ex_taken <= id_taken && !if_flush;
            ex_tag   <= id_tag;
        end
        mem_op  <= ex_op;
        mem_tag <= ex_tag;
        wb_op   <= mem_op;
        wb_tag  <= mem_tag;
    end

endmodule

`default_nettype wire

/* pipeline_tracker.sv */
`timescale 1ns/1ns
`default_nettype none

module pipeline_tracker #(
    parameter int NUM_STAGES = 5
) (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          accept,
    input  logic                          pc_stall,
    input  logic                          if_id_stall,
    input  logic                          if_flush,
    input  logic                          wb_valid,
    input  pipe_pkg::op_t                 wb_op,
    input  logic [pipe_pkg::TAG_W-1:0]    wb_tag,
    input  logic                          wb_flushed,
    input  logic                          trace_en,
    output logic                          retire_valid,
    output logic [pipe_pkg::TAG_W-1:0]    retire_tag,
    output pipe_pkg::op_t                 retire_op,
    output logic                          retire_flushed,
    output logic [trace_pkg::CYCLE_W-1:0] retire_fetch_cycle,
    output logic [trace_pkg::CNT_W-1:0]   retire_if_cycles,
    output logic [trace_pkg::CNT_W-1:0]   retire_id_cycles,
    output logic [trace_pkg::CYCLE_W-1:0] retire_cycle
);
    import pipe_pkg::*;
    import trace_pkg::*;

    localparam int LAST = NUM_STAGES - 1;

    logic [CYCLE_W-1:0] cycle_count;
    logic               if_adv;
    logic               id_adv;

    // slot 0 is fetch, slot LAST is write-back
    stage_t             slot_stage [NUM_STAGES];
    logic [CYCLE_W-1:0] slot_fetch [NUM_STAGES];
    logic [CNT_W-1:0]   slot_if    [NUM_STAGES];
    logic [CNT_W-1:0]   slot_id    [1:NUM_STAGES-1];

    function automatic logic [CNT_W-1:0] sat_inc(input logic [CNT_W-1:0] v);
        return (v == '1) ? v : v + 1'b1;
    endfunction

    // same advance rules as the core
    assign if_adv = !pc_stall || if_flush;
    assign id_adv = !if_id_stall || if_flush;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cycle_count <= '0;
        end else begin
            cycle_count <= cycle_count + 1'b1;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < NUM_STAGES; i++) begin
                slot_stage[i] <= EMPTY;
            end
        end else begin
            if (accept) begin
                slot_stage[0] <= FETCH;
            end else if (if_adv) begin
                slot_stage[0] <= EMPTY;
            end
            if (id_adv) begin
                slot_stage[1] <= (if_adv && slot_stage[0] != EMPTY) ? DECODE : EMPTY;
            end
            // held decode leaves a bubble behind it
            slot_stage[2] <= (id_adv && slot_stage[1] != EMPTY) ? EXECUTE : EMPTY;
            // past decode every slot moves each cycle, WB drains to EMPTY
            for (int i = 3; i < NUM_STAGES; i++) begin
                slot_stage[i] <= (slot_stage[i-1] != EMPTY) ? stage_t'(i + 1) : EMPTY;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            // stamp is the first cycle spent in fetch
            slot_fetch[0] <= cycle_count + 1'b1;
            slot_if[0]    <= CNT_W'(1);
        end else if (!if_adv) begin
            slot_if[0] <= sat_inc(slot_if[0]);
        end
        // fetch moving on means decode moves too
        if (if_adv) begin
            slot_fetch[1] <= slot_fetch[0];
            slot_if[1]    <= slot_if[0];
            slot_id[1]    <= CNT_W'(1);
        end else if (!id_adv) begin
            slot_id[1] <= sat_inc(slot_id[1]);
        end
        for (int i = 2; i < NUM_STAGES; i++) begin
            slot_fetch[i] <= slot_fetch[i-1];
            slot_if[i]    <= slot_if[i-1];
            slot_id[i]    <= slot_id[i-1];
        end
    end

    // record leaves as a single-cycle pulse while in write-back
    assign retire_valid       = trace_en && wb_valid && (slot_stage[LAST] == WRITE_BACK);
    assign retire_tag         = wb_tag;
    assign retire_op          = wb_op;
    assign retire_flushed     = wb_flushed;
    assign retire_fetch_cycle = slot_fetch[LAST];
    assign retire_if_cycles   = slot_if[LAST];
    assign retire_id_cycles   = slot_id[LAST];
    assign retire_cycle       = cycle_count;

endmodule

`default_nettype wire

/* trace_cfg_regs.sv */
`timescale 1ns/1ns
`default_nettype none

module trace_cfg_regs (
    input  logic        clk,
    input  logic        rst,
    input  logic        cfg_we,
    input  logic [1:0]  cfg_addr,
    input  logic [31:0] cfg_wdata,
    input  logic        retire_pulse,
    input  logic        flushed_pulse,
    input  logic        stall_level,
    output logic [31:0] cfg_rdata,
    output logic        trace_en,
    output logic        fetch_hold
);
    import trace_pkg::*;

    logic [31:0] retired_cnt;
    logic [31:0] flushed_cnt;
    logic [31:0] stall_cnt;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            trace_en    <= 1'b1;
            fetch_hold  <= 1'b0;
            retired_cnt <= '0;
            flushed_cnt <= '0;
            stall_cnt   <= '0;
        end else begin
            if (cfg_we && cfg_addr == CFG_CTRL) begin
                trace_en   <= cfg_wdata[0];
                fetch_hold <= cfg_wdata[1];
            end
            // any write to a counter clears it
            if (cfg_we && cfg_addr == CFG_RETIRED) begin
                retired_cnt <= '0;
            end else if (retire_pulse) begin
                retired_cnt <= retired_cnt + 1'b1;
            end
            if (cfg_we && cfg_addr == CFG_FLUSHED) begin
                flushed_cnt <= '0;
            end else if (flushed_pulse) begin
                flushed_cnt <= flushed_cnt + 1'b1;
            end
            if (cfg_we && cfg_addr == CFG_STALLS) begin
                stall_cnt <= '0;
            end else if (stall_level) begin
                stall_cnt <= stall_cnt + 1'b1;
            end
        end
    end

    always_comb begin
        case (cfg_addr)
            CFG_CTRL:    cfg_rdata = {30'd0, fetch_hold, trace_en};
            CFG_RETIRED: cfg_rdata = retired_cnt;
            CFG_FLUSHED: cfg_rdata = flushed_cnt;
            CFG_STALLS:  cfg_rdata = stall_cnt;
            default:     cfg_rdata = '0;
        endcase
    end

endmodule

`default_nettype wire

/* pipe_trace_top.sv */
`timescale 1ns/1ns
`default_nettype none

module pipe_trace_top #(
    parameter int NUM_STAGES = 5
) (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          instr_valid,
    input  pipe_pkg::op_t                 instr_op,
    input  logic [pipe_pkg::REG_W-1:0]    instr_rd,
    input  logic [pipe_pkg::REG_W-1:0]    instr_rs1,
    input  logic [pipe_pkg::REG_W-1:0]    instr_rs2,
    input  logic                          instr_taken,
    input  logic [pipe_pkg::TAG_W-1:0]    instr_tag,
    input  logic                          cfg_we,
    input  logic [1:0]                    cfg_addr,
    input  logic [31:0]                   cfg_wdata,
    output logic                          fetch_stall,
    output logic [31:0]                   cfg_rdata,
    output logic                          retire_valid,
    output logic [pipe_pkg::TAG_W-1:0]    retire_tag,
    output pipe_pkg::op_t                 retire_op,
    output logic                          retire_flushed,
    output logic [trace_pkg::CYCLE_W-1:0] retire_fetch_cycle,
    output logic [trace_pkg::CNT_W-1:0]   retire_if_cycles,
    output logic [trace_pkg::CNT_W-1:0]   retire_id_cycles,
    output logic [trace_pkg::CYCLE_W-1:0] retire_cycle
);
    import pipe_pkg::*;

    logic             pc_stall;
    logic             if_id_stall;
    logic             if_flush;
    logic             accept;
    logic             trace_en;
    logic             fetch_hold;
    logic             id_valid;
    logic [REG_W-1:0] id_rs1;
    logic [REG_W-1:0] id_rs2;
    logic             ex_valid;
    op_t              ex_op;
    logic [REG_W-1:0] ex_rd;
    logic             ex_taken;
    logic             wb_valid;
    op_t              wb_op;
    logic [TAG_W-1:0] wb_tag;
    logic             wb_flushed;
    logic             flushed_retire;

    assign accept         = instr_valid && !pc_stall;
    assign fetch_stall    = pc_stall;
    assign flushed_retire = wb_valid && wb_flushed;

    pipe_core u_pipe_core (
        .clk         (clk),
        .rst         (rst),
        .instr_valid (instr_valid),
        .instr_op    (instr_op),
        .instr_rd    (instr_rd),
        .instr_rs1   (instr_rs1),
        .instr_rs2   (instr_rs2),
        .instr_taken (instr_taken),
        .instr_tag   (instr_tag),
        .pc_stall    (pc_stall),
        .if_id_stall (if_id_stall),
        .if_flush    (if_flush),
        .id_valid    (id_valid),
        .id_rs1      (id_rs1),
        .id_rs2      (id_rs2),
        .ex_valid    (ex_valid),
        .ex_op       (ex_op),
        .ex_rd       (ex_rd),
        .ex_taken    (ex_taken),
        .wb_valid    (wb_valid),
        .wb_op       (wb_op),
        .wb_tag      (wb_tag),
        .wb_flushed  (wb_flushed)
    );

    hazard_unit u_hazard_unit (
        .id_valid    (id_valid),
        .id_rs1      (id_rs1),
        .id_rs2      (id_rs2),
        .ex_valid    (ex_valid),
        .ex_op       (ex_op),
        .ex_rd       (ex_rd),
        .ex_taken    (ex_taken),
        .fetch_hold  (fetch_hold),
        .pc_stall    (pc_stall),
        .if_id_stall (if_id_stall),
        .if_flush    (if_flush)
    );

    pipeline_tracker #(
        .NUM_STAGES (NUM_STAGES)
    ) u_pipeline_tracker (
        .clk                (clk),
        .rst                (rst),
        .accept             (accept),
        .pc_stall           (pc_stall),
        .if_id_stall        (if_id_stall),
        .if_flush           (if_flush),
        .wb_valid           (wb_valid),
        .wb_op              (wb_op),
        .wb_tag             (wb_tag),
        .wb_flushed         (wb_flushed),
        .trace_en           (trace_en),
        .retire_valid       (retire_valid),
        .retire_tag         (retire_tag),
        .retire_op          (retire_op),
        .retire_flushed     (retire_flushed),
        .retire_fetch_cycle (retire_fetch_cycle),
        .retire_if_cycles   (retire_if_cycles),
        .retire_id_cycles   (retire_id_cycles),
        .retire_cycle       (retire_cycle)
    );

    // counters see every write-back, traced or not
    trace_cfg_regs u_trace_cfg_regs (
        .clk           (clk),
        .rst           (rst),
        .cfg_we        (cfg_we),
        .cfg_addr      (cfg_addr),
        .cfg_wdata     (cfg_wdata),
        .retire_pulse  (wb_valid),
        .flushed_pulse (flushed_retire),
        .stall_level   (pc_stall),
        .cfg_rdata     (cfg_rdata),
        .trace_en      (trace_en),
        .fetch_hold    (fetch_hold)
    );

endmodule

`default_nettype wire

/* pipe_trace_chk.sv */
`timescale 1ns/1ns
`default_nettype none

module pipe_trace_chk (
    input wire logic                       clk,
    input wire logic                       rst,
    input wire logic                       fetch_stall,
    input wire logic                       if_flush,
    input wire logic                       if_id_stall,
    input wire logic                       id_valid,
    input wire logic                       wb_valid,
    input wire logic                       retire_valid,
    input wire logic [pipe_pkg::TAG_W-1:0] retire_tag
);

    int fail_count = 0;

    // flushed decode entry still travels to write-back
    assert property (@(posedge clk) disable iff (rst)
        if_flush && id_valid |-> ##3 wb_valid)
        else begin
            fail_count++;
            $error("flushed instruction in decode did not reach write-back");
        end

    // held decode entry waits one cycle, then moves on
    assert property (@(posedge clk) disable iff (rst)
        if_id_stall |-> ##4 wb_valid)
        else begin
            fail_count++;
            $error("stalled instruction in decode did not reach write-back");
        end

    assert property (@(posedge clk) disable iff (rst)
        retire_valid |=> !(retire_valid && retire_tag == $past(retire_tag)))
        else begin
            fail_count++;
            $error("same tag retired on two cycles in a row");
        end

    assert property (@(posedge clk)
        rst |-> !fetch_stall && !retire_valid && !if_flush && !if_id_stall)
        else begin
            fail_count++;
            $error("control output high during reset");
        end

endmodule

`default_nettype wire

/* tb_pipe_trace.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_pipe_trace;
    import pipe_pkg::*;
    import trace_pkg::*;

    // roughly 350 cycles of tests, generous margin
    localparam int MAX_CYCLES = 2000;

    logic clk = 1'b0;
    logic rst = 1'b1;
    logic instr_valid = 1'b0;
    op_t instr_op = OP_NOP;
    logic [REG_W-1:0] instr_rd = '0;
    logic [REG_W-1:0] instr_rs1 = '0;
    logic [REG_W-1:0] instr_rs2 = '0;
    logic instr_taken = 1'b0;
    logic [TAG_W-1:0] instr_tag = '0;
    logic cfg_we = 1'b0;
    logic [1:0] cfg_addr = '0;
    logic [31:0] cfg_wdata = '0;
    logic fetch_stall;
    logic [31:0] cfg_rdata;
    logic retire_valid;
    logic [TAG_W-1:0] retire_tag;
    op_t retire_op;
    logic retire_flushed;
    logic [CYCLE_W-1:0] retire_fetch_cycle;
    logic [CNT_W-1:0] retire_if_cycles;
    logic [CNT_W-1:0] retire_id_cycles;
    logic [CYCLE_W-1:0] retire_cycle;

    int cyc = 0;
    string test_name = "reset";
    logic [31:0] lfsr = 32'h3eef;
    logic [TAG_W-1:0] next_tag = 8'd1;
    logic [TAG_W-1:0] sent_q[$];

    // reference pipeline, index 0 is fetch
    logic m_v [5];
    logic [2:0] m_op [5];
    logic [REG_W-1:0] m_rd [5];
    logic [REG_W-1:0] m_rs1 [5];
    logic [REG_W-1:0] m_rs2 [5];
    logic m_tk [5];
    logic m_fl [5];
    logic [31:0] m_fc [5];
    logic [CNT_W-1:0] m_ic [5];
    logic [CNT_W-1:0] m_dc [5];
    logic [31:0] m_cycle;
    logic [31:0] m_ret;
    logic [31:0] m_flc;
    logic [31:0] m_stc;
    logic m_ten;
    logic m_hold;

    // actual retire fields by tag, for the directed checks
    logic [CNT_W-1:0] seen_if [256];
    logic [CNT_W-1:0] seen_id [256];
    logic seen_fl [256];

    pipe_trace_top #(.NUM_STAGES(5)) u_pipe_trace_top (
        .clk(clk), .rst(rst),
        .instr_valid(instr_valid), .instr_op(instr_op), .instr_rd(instr_rd),
        .instr_rs1(instr_rs1), .instr_rs2(instr_rs2), .instr_taken(instr_taken),
        .instr_tag(instr_tag),
        .cfg_we(cfg_we), .cfg_addr(cfg_addr), .cfg_wdata(cfg_wdata),
        .fetch_stall(fetch_stall), .cfg_rdata(cfg_rdata),
        .retire_valid(retire_valid), .retire_tag(retire_tag), .retire_op(retire_op),
        .retire_flushed(retire_flushed), .retire_fetch_cycle(retire_fetch_cycle),
        .retire_if_cycles(retire_if_cycles), .retire_id_cycles(retire_id_cycles),
        .retire_cycle(retire_cycle)
    );

    bind pipe_trace_top pipe_trace_chk u_pipe_trace_chk (
        .clk(clk), .rst(rst), .fetch_stall(fetch_stall), .if_flush(if_flush),
        .if_id_stall(if_id_stall), .id_valid(id_valid), .wb_valid(wb_valid),
        .retire_valid(retire_valid), .retire_tag(retire_tag)
    );

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cyc++;
        if (cyc >= MAX_CYCLES) begin
            $display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
            $display("Some tests failed");
            $fatal(1);
        end
    end

    task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            $display("[FAIL] %s expected %0h actual %0h", name, exp, act);
            $display("Some tests failed");
            $fatal(1);
        end
    endtask

    // one bit per step of the Galois LFSR
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r = {r[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
        end
        return r;
    endfunction

    task automatic copy_stage(input int d, input int s);
        m_v[d] = m_v[s];
        m_op[d] = m_op[s];
        m_rd[d] = m_rd[s];
        m_rs1[d] = m_rs1[s];
        m_rs2[d] = m_rs2[s];
        m_tk[d] = m_tk[s];
        m_fl[d] = m_fl[s];
        m_fc[d] = m_fc[s];
        m_ic[d] = m_ic[s];
        m_dc[d] = m_dc[s];
    endtask

    function automatic logic model_busy();
        return m_v[0] || m_v[1] || m_v[2] || m_v[3] || m_v[4];
    endfunction

    // compares the state before each edge, then steps the model
    always @(posedge clk) begin : monitor
        logic ld_use;
        logic flush;
        logic pc;
        logic [TAG_W-1:0] t;
        if (rst) begin
            for (int i = 0; i < 5; i++) begin
                m_v[i] = 1'b0;
            end
            m_cycle = '0;
            m_ret = '0;
            m_flc = '0;
            m_stc = '0;
            m_ten = 1'b1;
            m_hold = 1'b0;
        end else begin
            ld_use = m_v[1] && m_v[2] && m_op[2] == OP_LOAD && m_rd[2] != 0
                && (m_rs1[1] == m_rd[2] || m_rs2[1] == m_rd[2]);
            flush = m_v[2] && m_op[2] == OP_BRANCH && m_tk[2];
            pc = ld_use || m_hold;
            check({test_name, " fetch_stall"}, pc, fetch_stall);
            if (m_v[4]) begin
                t = sent_q.pop_front();
                check({test_name, " tag"}, t, retire_tag);
                check({test_name, " op"}, m_op[4], retire_op);
                check({test_name, " flushed"}, m_fl[4], retire_flushed);
                check({test_name, " retire_valid"}, m_ten, retire_valid);
                if (m_ten) begin
                    check({test_name, " fetch_cycle"}, m_fc[4], retire_fetch_cycle);
                    check({test_name, " if_cycles"}, m_ic[4], retire_if_cycles);
                    check({test_name, " id_cycles"}, m_dc[4], retire_id_cycles);
                    check({test_name, " retire_cycle"}, m_cycle, retire_cycle);
                    check({test_name, " latency"},
                        m_fc[4] + 4 + (m_ic[4] - 1) + (m_dc[4] - 1), retire_cycle);
                end
                seen_if[t] = retire_if_cycles;
                seen_id[t] = retire_id_cycles;
                seen_fl[t] = retire_flushed;
            end else begin
                check({test_name, " idle retire_valid"}, 1'b0, retire_valid);
            end
            // counters, a write clears
            m_ret = (cfg_we && cfg_addr == CFG_RETIRED) ? 0 : m_ret + m_v[4];
            m_flc = (cfg_we && cfg_addr == CFG_FLUSHED) ? 0 : m_flc + (m_v[4] && m_fl[4]);
            m_stc = (cfg_we && cfg_addr == CFG_STALLS) ? 0 : m_stc + pc;
            if (cfg_we && cfg_addr == CFG_CTRL) begin
                m_ten = cfg_wdata[0];
                m_hold = cfg_wdata[1];
            end
            copy_stage(4, 3);
            copy_stage(3, 2);
            if (ld_use && !flush) begin
                m_v[2] = 1'b0;
                m_dc[1] = (m_dc[1] == '1) ? m_dc[1] : m_dc[1] + 1;
            end else begin
                copy_stage(2, 1);
                m_fl[2] = m_fl[1] || flush;
                m_tk[2] = m_tk[1] && !flush;
                if (!pc || flush) begin
                    copy_stage(1, 0);
                    m_fl[1] = flush;
                    m_tk[1] = m_tk[0] && !flush;
                    m_dc[1] = 1;
                end else begin
                    m_v[1] = 1'b0;
                end
            end
            if (instr_valid && !pc) begin
                m_v[0] = 1'b1;
                m_op[0] = instr_op;
                m_rd[0] = instr_rd;
                m_rs1[0] = instr_rs1;
                m_rs2[0] = instr_rs2;
                m_tk[0] = instr_taken;
                // first cycle spent in fetch
                m_fc[0] = m_cycle + 1;
                m_ic[0] = 1;
            end else if (!pc || flush) begin
                m_v[0] = 1'b0;
            end else begin
                m_ic[0] = (m_ic[0] == '1) ? m_ic[0] : m_ic[0] + 1;
            end
            m_cycle = m_cycle + 1;
        end
    end

    // returns once the next edge will accept the instruction
    task automatic send(input op_t op, input logic [REG_W-1:0] rd,
                        input logic [REG_W-1:0] rs1, input logic [REG_W-1:0] rs2,
                        input logic taken, output logic [TAG_W-1:0] tag);
        @(negedge clk);
        tag = next_tag;
        next_tag++;
        instr_valid = 1'b1;
        instr_op = op;
        instr_rd = rd;
        instr_rs1 = rs1;
        instr_rs2 = rs2;
        instr_taken = taken;
        instr_tag = tag;
        #1;
        while (fetch_stall) begin
            @(negedge clk);
            #1;
        end
        sent_q.push_back(tag);
    endtask

    task automatic drain();
        @(negedge clk);
        instr_valid = 1'b0;
        while (model_busy()) begin
            @(negedge clk);
        end
    endtask

    task automatic cfg_write(input logic [1:0] addr, input logic [31:0] data);
        @(negedge clk);
        cfg_we = 1'b1;
        cfg_addr = addr;
        cfg_wdata = data;
        @(negedge clk);
        cfg_we = 1'b0;
    endtask

    task automatic read_check(input logic [1:0] addr, input logic [31:0] exp);
        @(negedge clk);
        cfg_addr = addr;
        #1;
        check({test_name, " cfg_rdata"}, exp, cfg_rdata);
    endtask

    task automatic reset_state();
        test_name = "reset";
        check("reset fetch_stall", 0, fetch_stall);
        check("reset retire_valid", 0, retire_valid);
        read_check(CFG_CTRL, 32'd1);
        read_check(CFG_RETIRED, 0);
        read_check(CFG_FLUSHED, 0);
        read_check(CFG_STALLS, 0);
    endtask

    task automatic alu_stream();
        logic [TAG_W-1:0] t [6];
        test_name = "alu_stream";
        for (int i = 0; i < 6; i++) begin
            send(OP_ALU, REG_W'(i + 1), REG_W'(i), 0, 1'b0, t[i]);
        end
        drain();
        for (int i = 0; i < 6; i++) begin
            check("alu_stream if_cycles", 1, seen_if[t[i]]);
            check("alu_stream id_cycles", 1, seen_id[t[i]]);
        end
    endtask

    task automatic load_use_stall();
        logic [TAG_W-1:0] t [4];
        test_name = "load_use";
        cfg_write(CFG_STALLS, 0);
        send(OP_LOAD, 2, 0, 0, 1'b0, t[0]);
        send(OP_ALU, 5, 2, 0, 1'b0, t[1]);
        send(OP_LOAD, 3, 0, 0, 1'b0, t[2]);
        send(OP_ALU, 6, 4, 1, 1'b0, t[3]);
        drain();
        check("load_use dependent id_cycles", 2, seen_id[t[1]]);
        check("load_use independent id_cycles", 1, seen_id[t[3]]);
        read_check(CFG_STALLS, 1);
    endtask

    task automatic branch_flush();
        logic [TAG_W-1:0] t [7];
        test_name = "branch";
        send(OP_BRANCH, 0, 1, 2, 1'b1, t[0]);
        send(OP_ALU, 1, 0, 0, 1'b0, t[1]);
        send(OP_ALU, 2, 0, 0, 1'b0, t[2]);
        send(OP_ALU, 3, 0, 0, 1'b0, t[3]);
        send(OP_BRANCH, 0, 1, 2, 1'b0, t[4]);
        send(OP_ALU, 4, 0, 0, 1'b0, t[5]);
        send(OP_ALU, 5, 0, 0, 1'b0, t[6]);
        drain();
        check("branch taken itself", 0, seen_fl[t[0]]);
        check("branch first follower", 1, seen_fl[t[1]]);
        check("branch second follower", 1, seen_fl[t[2]]);
        check("branch third follower", 0, seen_fl[t[3]]);
        for (int i = 4; i < 7; i++) begin
            check("branch not taken", 0, seen_fl[t[i]]);
        end
    endtask

    task automatic cfg_counters();
        logic [TAG_W-1:0] t;
        test_name = "cfg";
        cfg_write(CFG_RETIRED, 0);
        cfg_write(CFG_FLUSHED, 0);
        cfg_write(CFG_STALLS, 0);
        // hold rises on the same edge that accepts the instruction
        send(OP_ALU, 1, 0, 0, 1'b0, t);
        cfg_we = 1'b1;
        cfg_addr = CFG_CTRL;
        cfg_wdata = 32'd3;
        @(negedge clk);
        cfg_we = 1'b0;
        instr_valid = 1'b0;
        repeat (3) @(negedge clk);
        cfg_write(CFG_CTRL, 32'd1);
        drain();
        check("cfg held if_cycles", 6, seen_if[t]);
        read_check(CFG_STALLS, 5);
        cfg_write(CFG_CTRL, 32'd0);
        for (int i = 0; i < 3; i++) begin
            send(OP_ALU, 2, 1, 0, 1'b0, t);
        end
        drain();
        cfg_write(CFG_CTRL, 32'd1);
        read_check(CFG_RETIRED, 4);
        read_check(CFG_RETIRED, m_ret);
        read_check(CFG_FLUSHED, m_flc);
        cfg_write(CFG_RETIRED, 32'hffff);
        cfg_write(CFG_STALLS, 32'd7);
        read_check(CFG_RETIRED, 0);
        read_check(CFG_STALLS, 0);
        read_check(CFG_FLUSHED, 0);
    endtask

    task automatic random_mix();
        logic [TAG_W-1:0] t;
        op_t op;
        logic [REG_W-1:0] rd;
        logic [REG_W-1:0] rs1;
        logic [REG_W-1:0] rs2;
        logic tk;
        test_name = "random";
        for (int i = 0; i < 40; i++) begin
            op = op_t'(rand_bits(3) % 5);
            rd = REG_W'(rand_bits(REG_W));
            rs1 = REG_W'(rand_bits(REG_W));
            rs2 = REG_W'(rand_bits(REG_W));
            tk = (rand_bits(1) != 0);
            send(op, rd, rs1, rs2, tk, t);
        end
        drain();
        read_check(CFG_RETIRED, m_ret);
        read_check(CFG_FLUSHED, m_flc);
        read_check(CFG_STALLS, m_stc);
    endtask

    initial begin
        repeat (16) @(negedge clk);
        rst = 1'b0;
        reset_state();
        alu_stream();
        load_use_stall();
        branch_flush();
        cfg_counters();
        random_mix();
        check("queue empty at end", 0, sent_q.size());
        if (u_pipe_trace_top.u_pipe_trace_chk.fail_count == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* list.f */
pipe_pkg.sv
trace_pkg.sv
hazard_unit.sv
pipe_core.sv
pipeline_tracker.sv
trace_cfg_regs.sv
pipe_trace_top.sv
pipe_trace_chk.sv
tb_pipe_trace.sv

/* Bender.yml */
package:
  name: pipe_trace

sources:
  - pipe_pkg.sv
  - trace_pkg.sv
  - hazard_unit.sv
  - pipe_core.sv
  - pipeline_tracker.sv
  - trace_cfg_regs.sv
  - pipe_trace_top.sv
  - target: test
    files:
      - pipe_trace_chk.sv
      - tb_pipe_trace.sv
